/* rtl/mic_array_top.sv */
`timescale 1ns/1ps
`include "mic_consts.svh"

module mic_array_top import mic_pkg::*; (
  input  logic                     clk_in,
  input  logic                     rst_n,
  input  logic [`MIC_CHANNELS-1:0] mic_data,
  output logic                     mic_sck,
  output logic                     mic_ws,
  output mic_frame_t               audio_data,
  output logic                     audio_valid,
  input  logic                     audio_ready,
  input  logic [`MIC_CHANNELS-1:0] play_sel,
  output logic                     pdm_out,
  output logic                     dropped
);

  logic shift_en;
  logic load_frame;
  logic take;

  // bit timing shared by timer, FSM and deserializer
  mic_timing_if tim ();

  mic_clock_gen u_clock_gen (
    .clk_in (clk_in),
    .rst_n  (rst_n),
    .tim    (tim.timer)
  );

  // shared bit clock and word select for all four mics
  assign mic_sck = tim.sck;
  assign mic_ws  = tim.ws;

  mic_capture_fsm u_capture_fsm (
    .clk_in      (clk_in),
    .rst_n       (rst_n),
    .tim         (tim.ctrl),
    .audio_ready (audio_ready),
    .shift_en    (shift_en),
    .load_frame  (load_frame),
    .audio_valid (audio_valid),
    .dropped     (dropped)
  );

  mic_deserializer u_deserializer (
    .clk_in     (clk_in),
    .rst_n      (rst_n),
    .tim        (tim.data),
    .mic_data   (mic_data),
    .shift_en   (shift_en),
    .load_frame (load_frame),
    .frame      (audio_data)
  );

  // frame handed off downstream this cycle
  assign take = audio_valid && audio_ready;

  pdm_playback u_pdm_playback (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .frame    (audio_data),
    .take     (take),
    .play_sel (play_sel),
    .pdm_out  (pdm_out)
  );

endmodule

/* rtl/mic_capture_fsm.sv */
`timescale 1ns/1ps
`include "mic_consts.svh"

module mic_capture_fsm import mic_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_n,
  mic_timing_if.ctrl  tim,
  input  logic        audio_ready,
  output logic        shift_en,
  output logic        load_frame,
  output logic        audio_valid,
  output logic        dropped
);

  capture_state_t state_q;
  capture_state_t state_d;
  logic           slot_start;
  logic           in_window;
  logic           word_end;
  logic           accept;

  // first sck period of the captured half
  assign slot_start = !tim.ws && (tim.bit_index == '0);

  // msb at index 1, lsb at index MIC_SAMPLE_W
  assign in_window = (tim.bit_index >= `MIC_BIT_IDX_W'(1)) &&
                     (tim.bit_index <= `MIC_BIT_IDX_W'(`MIC_SAMPLE_W));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      state_d = SYNC;
      SYNC:      if (slot_start) state_d = SHIFT;
      SHIFT:     if (tim.word_done) state_d = WAIT_WORD;
      WAIT_WORD: if (slot_start) state_d = SHIFT;
      default:   state_d = IDLE;
    endcase
  end

  assign shift_en = (state_q == SHIFT) && in_window;
  assign word_end = (state_q == SHIFT) && tim.word_done;
  assign accept   = audio_valid && audio_ready;

  // the held frame must be gone or leaving this cycle
  assign load_frame = word_end && (!audio_valid || audio_ready);

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      audio_valid <= 1'b0;
      dropped     <= 1'b0;
    end else begin
      state_q <= state_d;
      // a load wins over a transfer in the same cycle
      if (load_frame) begin
        audio_valid <= 1'b1;
      end else if (accept) begin
        audio_valid <= 1'b0;
      end
      // sticky until reset
      if (word_end && !load_frame) begin
        dropped <= 1'b1;
      end
    end
  end

endmodule

/* rtl/mic_clock_gen.sv */
`timescale 1ns/1ps
`include "mic_consts.svh"

module mic_clock_gen (
  input logic         clk_in,
  input logic         rst_n,
  mic_timing_if.timer tim
);

  localparam int DIV_W = $clog2(`MIC_SCK_DIV);

  logic [DIV_W-1:0]          div_cnt;
  logic                      half_end;
  logic                      sck_q;
  logic                      ws_q;
  logic                      tick_q;
  logic                      done_q;
  logic [`MIC_BIT_IDX_W-1:0] idx_q;

  // last clk_in cycle of an sck half
  assign half_end = (div_cnt == DIV_W'(`MIC_SCK_DIV - 1));

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      sck_q   <= 1'b0;
      ws_q    <= 1'b0;
      tick_q  <= 1'b0;
      done_q  <= 1'b0;
      idx_q   <= '0;
    end else begin
      // strobes line up with sck going high
      tick_q <= half_end && !sck_q;
      done_q <= half_end && !sck_q && !ws_q &&
                (idx_q == `MIC_BIT_IDX_W'(`MIC_SAMPLE_W));
      if (half_end) begin
        div_cnt <= '0;
        sck_q   <= !sck_q;
        // index and ws move on the falling edge
        if (sck_q) begin
          if (idx_q == `MIC_BIT_IDX_W'(`MIC_SLOT_SCKS - 1)) begin
            idx_q <= '0;
            ws_q  <= !ws_q;
          end else begin
            idx_q <= idx_q + 1'b1;
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  assign tim.sck       = sck_q;
  assign tim.ws        = ws_q;
  assign tim.bit_tick  = tick_q;
  assign tim.bit_index = idx_q;
  assign tim.word_done = done_q;

endmodule

/* rtl/mic_consts.svh */
`ifndef MIC_CONSTS_SVH
`define MIC_CONSTS_SVH

// bits per pcm sample
`define MIC_SAMPLE_W 16

// microphones on the board, one data line each
`define MIC_CHANNELS 4

// clk_in cycles per sck half period
`define MIC_SCK_DIV 4

// sck periods in one word select half
`define MIC_SLOT_SCKS 32

// holds 0 .. MIC_SLOT_SCKS-1
`define MIC_BIT_IDX_W 5

`endif

/* rtl/mic_deserializer.sv */
`timescale 1ns/1ps
`include "mic_consts.svh"

module mic_deserializer import mic_pkg::*; (
  input  logic                      clk_in,
  input  logic                      rst_n,
  mic_timing_if.data                tim,
  input  logic [`MIC_CHANNELS-1:0]  mic_data,
  input  logic                      shift_en,
  input  logic                      load_frame,
  output mic_frame_t                frame
);

  mic_frame_t shift_q;
  mic_frame_t shift_d;

  // one bit per line, msb enters first
  always_comb begin
    shift_d = shift_q;
    if (shift_en && tim.bit_tick) begin
      for (int ch = 0; ch < `MIC_CHANNELS; ch++) begin
        shift_d[ch] = {shift_q[ch][`MIC_SAMPLE_W-2:0], mic_data[ch]};
      end
    end
  end

  always_ff @(posedge clk_in) begin
    shift_q <= shift_d;
  end

  // load takes shift_d so the lsb of this tick is included
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      frame <= '0;
    end else if (load_frame) begin
      frame <= shift_d;
    end
  end

endmodule

/* rtl/mic_pkg.sv */
`include "mic_consts.svh"

package mic_pkg;

  // one signed pcm word from a microphone
  typedef logic signed [`MIC_SAMPLE_W-1:0] mic_sample_t;

  // all channels of one word period
  // channel 0 sits in the low slot
  typedef mic_sample_t [`MIC_CHANNELS-1:0] mic_frame_t;

  // capture FSM states
  typedef enum logic [1:0] {
    IDLE,
    SYNC,
    SHIFT,
    WAIT_WORD
  } capture_state_t;

endpackage

/* rtl/mic_timing_if.sv */
`timescale 1ns/1ps
`include "mic_consts.svh"

interface mic_timing_if;

  // bit clock and word select levels, as sent to the mics
  logic                      sck;
  logic                      ws;
  // single cycle pulse with the rising sck
  logic                      bit_tick;
  // sck rises seen so far in this ws half
  logic [`MIC_BIT_IDX_W-1:0] bit_index;
  // tick of the last data bit in the ws low half
  logic                      word_done;

  modport timer (output sck, ws, bit_tick, bit_index, word_done);
  modport ctrl (input ws, bit_index, word_done);
  modport data (input bit_tick);

endinterface

/* rtl/pdm_playback.sv */
`timescale 1ns/1ps
`include "mic_consts.svh"

module pdm_playback import mic_pkg::*; (
  input  logic                     clk_in,
  input  logic                     rst_n,
  input  mic_frame_t               frame,
  input  logic                     take,
  input  logic [`MIC_CHANNELS-1:0] play_sel,
  output logic                     pdm_out
);

  mic_sample_t               level_q;
  mic_sample_t               sel_sample;
  logic [`MIC_SAMPLE_W-1:0]  offset;
  logic [`MIC_SAMPLE_W-1:0]  acc_q;
  logic [`MIC_SAMPLE_W:0]    acc_sum;

  // lowest set bit wins
  // nothing selected keeps the old level
  always_comb begin
    sel_sample = level_q;
    for (int ch = `MIC_CHANNELS - 1; ch >= 0; ch--) begin
      if (play_sel[ch]) begin
        sel_sample = frame[ch];
      end
    end
  end

  // signed to offset binary, flip the sign bit
  assign offset = {~level_q[`MIC_SAMPLE_W-1], level_q[`MIC_SAMPLE_W-2:0]};

  // first order sigma delta, carry is the density bit
  assign acc_sum = {1'b0, acc_q} + {1'b0, offset};

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      level_q <= '0;
      acc_q   <= '0;
      pdm_out <= 1'b0;
    end else begin
      if (take) begin
        level_q <= sel_sample;
      end
      acc_q   <= acc_sum[`MIC_SAMPLE_W-1:0];
      pdm_out <= acc_sum[`MIC_SAMPLE_W];
    end
  end

endmodule

/* sim.f */
+incdir+rtl
rtl/mic_pkg.sv
rtl/mic_timing_if.sv
rtl/mic_clock_gen.sv
rtl/mic_capture_fsm.sv
rtl/mic_deserializer.sv
rtl/pdm_playback.sv
rtl/mic_array_top.sv
tb/tb_mic_array.sv

/* tb/tb_mic_array.sv */
`timescale 1ns/1ps
`include "mic_consts.svh"

module tb_mic_array import mic_pkg::*; ();

  localparam int timeout_cycles = 12000;
  // play_sel values used after each transfer
  // lowest nibble first
  localparam logic [23:0] sel_seq = 24'h2f_8c_06;

  logic                     clk_in;
  logic                     rst_n;
  logic [`MIC_CHANNELS-1:0] mic_data;
  logic                     mic_sck;
  logic                     mic_ws;
  mic_frame_t               audio_data;
  logic                     audio_valid;
  logic                     audio_ready;
  logic [`MIC_CHANNELS-1:0] play_sel;
  logic                     pdm_out;
  logic                     dropped;

  // mic line model state
  mic_sample_t cur_samp [`MIC_CHANNELS];
  logic        sck_prev;
  logic        ws_prev;
  logic        sck_rise;
  int          bit_pos;
  // reference model state
  string       phase;
  int          cyc;
  int          rel_cyc;
  int          word_cnt;
  int          xfer_cnt;
  int          last_rise;
  int          last_ws_edge;
  int          word_cyc;
  logic        mon_ws;
  logic        valid_seen;
  logic        valid_exp;
  logic        drop_exp;
  logic        pdm_exp;
  logic        take_seen;
  mic_frame_t  held_exp;
  mic_sample_t ref_level;
  logic [`MIC_SAMPLE_W-1:0] ref_acc;
  logic [`MIC_SAMPLE_W-1:0] acc_next;

  mic_array_top u_dut (
    .clk_in      (clk_in),
    .rst_n       (rst_n),
    .mic_data    (mic_data),
    .mic_sck     (mic_sck),
    .mic_ws      (mic_ws),
    .audio_data  (audio_data),
    .audio_valid (audio_valid),
    .audio_ready (audio_ready),
    .play_sel    (play_sel),
    .pdm_out     (pdm_out),
    .dropped     (dropped)
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_frame(input string name, input mic_frame_t exp, input mic_frame_t act);
    if (act !== exp) begin
      $display("FAILED %s/%s: expected %h, actual %h", phase, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s/%s: expected %b, actual %b", phase, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_timing(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAILED %s/%s: expected %0d cycles, actual %0d cycles", phase, name, exp, act);
      abort_run();
    end
  endtask

  // channel 0 in the low slot
  function automatic mic_frame_t expected_frame(input mic_sample_t s0, input mic_sample_t s1,
                                                input mic_sample_t s2, input mic_sample_t s3);
    return {s3, s2, s1, s0};
  endfunction

  // level plus half scale gives the offset binary value
  // overflow out of the top bit is the pdm bit
  function automatic logic pdm_ref(input mic_sample_t level,
                                   input logic [`MIC_SAMPLE_W-1:0] acc_in,
                                   output logic [`MIC_SAMPLE_W-1:0] acc_out);
    int sum;
    sum = int'(acc_in) + int'(level) + (1 << (`MIC_SAMPLE_W - 1));
    acc_out = sum[`MIC_SAMPLE_W-1:0];
    return (sum >= (1 << `MIC_SAMPLE_W));
  endfunction

  // lowest set bit picks the channel
  // no bit set keeps the level
  function automatic mic_sample_t select_level(input mic_frame_t fr,
                                               input logic [`MIC_CHANNELS-1:0] sel,
                                               input mic_sample_t old);
    mic_sample_t lvl;
    bit          found;
    lvl = old;
    found = 1'b0;
    for (int ch = 0; ch < `MIC_CHANNELS; ch++) begin
      if (sel[ch] && !found) begin
        lvl = fr[ch];
        found = 1'b1;
      end
    end
    return lvl;
  endfunction

  task automatic draw_slot();
    for (int ch = 0; ch < `MIC_CHANNELS; ch++) begin
      cur_samp[ch] = mic_sample_t'($urandom);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_in);
    #2;
  endtask

  task automatic wait_ws(input logic level);
    while (mic_ws !== level) next_cycle();
  endtask

  task automatic wait_transfers(input int target);
    while (xfer_cnt < target) next_cycle();
  endtask

  // mic models drive a new bit after each falling sck
  always @(posedge clk_in) begin
    #2;
    sck_rise = mic_sck && !sck_prev;
    if (!mic_sck && sck_prev) begin
      if (mic_ws !== ws_prev) bit_pos = 0;
      else bit_pos++;
    end
    // fresh samples for every ws low slot
    if (!mic_ws && ws_prev) draw_slot();
    sck_prev = mic_sck;
    ws_prev = mic_ws;
    for (int ch = 0; ch < `MIC_CHANNELS; ch++) begin
      if (!mic_ws && bit_pos >= 1 && bit_pos <= `MIC_SAMPLE_W)
        mic_data[ch] = cur_samp[ch][`MIC_SAMPLE_W - bit_pos];
      else
        mic_data[ch] = 1'($urandom);
    end
  end

  always @(posedge clk_in) begin
    cyc++;
    if (cyc >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      abort_run();
    end
  end

  // compare process samples mid cycle
  always @(negedge clk_in) begin
    if (!rst_n) begin
      check_bit("reset audio_valid", 1'b0, audio_valid);
      check_bit("reset dropped", 1'b0, dropped);
      check_bit("reset mic_sck", 1'b0, mic_sck);
      check_bit("reset mic_ws", 1'b0, mic_ws);
    end else begin
      rel_cyc++;
      if (rel_cyc == 1) begin
        check_bit("mic_sck after reset", 1'b0, mic_sck);
        check_bit("mic_ws after reset", 1'b0, mic_ws);
      end
      if (sck_rise) begin
        if (last_rise >= 0) check_timing("sck period", 8, rel_cyc - last_rise);
        last_rise = rel_cyc;
      end
      if (mic_ws !== mon_ws) begin
        if (last_ws_edge >= 0) check_timing("ws half", 256, rel_cyc - last_ws_edge);
        last_ws_edge = rel_cyc;
        mon_ws = mic_ws;
      end
      if (audio_valid && !valid_seen) check_timing("valid latency", 1, rel_cyc - word_cyc);
      valid_seen = audio_valid;
      check_bit("audio_valid", valid_exp, audio_valid);
      check_bit("dropped", drop_exp, dropped);
      // held frame stays put until it is taken
      if (valid_exp) check_frame("audio_data", held_exp, audio_data);
      check_bit("pdm_out", pdm_exp, pdm_out);
      pdm_exp = pdm_ref(ref_level, ref_acc, acc_next);
      ref_acc = acc_next;
      take_seen = valid_exp && audio_ready;
      if (take_seen) begin
        xfer_cnt++;
        ref_level = select_level(held_exp, play_sel, ref_level);
      end
      // tick of the lsb in the ws low half
      if (sck_rise && !mic_ws && bit_pos == `MIC_SAMPLE_W) begin
        word_cnt++;
        if (valid_exp && !audio_ready) begin
          drop_exp = 1'b1;
        end else begin
          held_exp = expected_frame(cur_samp[0], cur_samp[1], cur_samp[2], cur_samp[3]);
          valid_exp = 1'b1;
          word_cyc = rel_cyc;
        end
      end else if (take_seen) begin
        valid_exp = 1'b0;
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    audio_ready = 1'b0;
    play_sel = '0;
    mic_data = '0;
    sck_prev = 1'b0;
    ws_prev = 1'b0;
    sck_rise = 1'b0;
    bit_pos = 0;
    phase = "reset";
    cyc = 0;
    rel_cyc = 0;
    word_cnt = 0;
    xfer_cnt = 0;
    last_rise = -1;
    last_ws_edge = -1;
    word_cyc = 0;
    mon_ws = 1'b0;
    valid_seen = 1'b0;
    valid_exp = 1'b0;
    drop_exp = 1'b0;
    pdm_exp = 1'b0;
    take_seen = 1'b0;
    held_exp = '0;
    ref_level = '0;
    ref_acc = '0;
    void'($urandom(71));
    draw_slot();
    repeat (10) @(posedge clk_in);
    #2;
    rst_n = 1'b1;
    // capture with ready high
    // new playback channel after each frame
    phase = "capture";
    audio_ready = 1'b1;
    play_sel = 4'b0001;
    for (int i = 0; i < 6; i++) begin
      wait_transfers(xfer_cnt + 1);
      play_sel = sel_seq[i*4 +: 4];
    end
    // stall over two slots so the second word is dropped
    phase = "back-pressure";
    wait_ws(1'b1);
    audio_ready = 1'b0;
    begin : stall
      int start_words;
      start_words = word_cnt;
      while (word_cnt < start_words + 2) next_cycle();
    end
    wait_ws(1'b1);
    check_bit("dropped after overrun", 1'b1, dropped);
    audio_ready = 1'b1;
    wait_transfers(xfer_cnt + 1);
    phase = "playback";
    for (int i = 0; i < 4; i++) begin
      play_sel = sel_seq[(5 - i)*4 +: 4];
      wait_transfers(xfer_cnt + 1);
    end
    repeat (16) next_cycle();
    $display("RESULT: PASS");
    $finish;
  end

endmodule
